// File: cache_pkg.sv
package cache_pkg;

	// word and line geometry
	localparam int WORD_W     = 16;
	localparam int LINE_WORDS = 4;
	localparam int LINE_W     = LINE_WORDS * WORD_W;
	localparam int NUM_LINES  = 8;

	// address split into tag, index and offset
	localparam int OFFSET_W = 2;
	localparam int INDEX_W  = 3;
	localparam int TAG_W    = WORD_W - INDEX_W - OFFSET_W;

	// fixed DMA command raised on an external interrupt
	localparam logic [WORD_W-1:0] DMA_ADDR = 16'h0017;
	localparam logic [WORD_W-1:0] DMA_LEN  = 16'd12;

	// cache FSM states with the instruction cache using the first four
	localparam logic [2:0] ST_IDLE    = 3'd0;
	localparam logic [2:0] ST_LOOKUP  = 3'd1;
	localparam logic [2:0] ST_FILL    = 3'd2;
	localparam logic [2:0] ST_RESPOND = 3'd3;
	localparam logic [2:0] ST_WR_WAIT = 3'd4;
	localparam logic [2:0] ST_WRITE   = 3'd5;

	// one address word seen as a memory address or as cache fields
	typedef union packed {
		logic [WORD_W-1:0] raw;
		struct packed {
			logic [TAG_W-1:0]    tag;
			logic [INDEX_W-1:0]  index;
			logic [OFFSET_W-1:0] offset;
		} fields;
	} cache_addr_u;

	// one memory line with word 0 at the low end
	typedef logic [LINE_WORDS-1:0][WORD_W-1:0] cache_line_t;

	typedef struct packed {
		logic              read;
		logic              write;
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
	} cpu_req_t;

	// port 1 line read
	typedef struct packed {
		logic              read;
		logic [WORD_W-1:0] addr;
	} mem_rd_req_t;

	// port 2 line write
	typedef struct packed {
		logic              write;
		logic [WORD_W-1:0] addr;
		cache_line_t       data;
	} mem_wr_req_t;

	typedef struct packed {
		logic              valid;
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] len;
	} dma_cmd_t;

endpackage

// File: instr_cache.sv
`timescale 1ns/10ps

module instr_cache (
	input  logic                         clk,
	input  logic                         i_arst_n,
	input  cache_pkg::cpu_req_t          i_req,
	output logic                         o_ready,
	output logic [cache_pkg::WORD_W-1:0] o_rdata,
	output cache_pkg::mem_rd_req_t       o_mem_req,
	input  logic                         i_mem_ready,
	input  cache_pkg::cache_line_t       i_mem_data
);

	logic [2:0]                      state_q;
	cache_pkg::cache_addr_u          req_addr_q;
	cache_pkg::cache_addr_u          line_addr;
	logic [cache_pkg::NUM_LINES-1:0] valid_q;
	logic [cache_pkg::TAG_W-1:0]     tag_mem [cache_pkg::NUM_LINES];
	logic [cache_pkg::LINE_W-1:0]    line_mem [cache_pkg::NUM_LINES];
	cache_pkg::cache_line_t          cur_line;
	logic                            hit;
	logic                            fill_done;

	// lookup on the captured address
	always_comb begin
		cur_line = line_mem[req_addr_q.fields.index];
		hit = valid_q[req_addr_q.fields.index] &&
			(tag_mem[req_addr_q.fields.index] == req_addr_q.fields.tag);
		line_addr = req_addr_q;
		line_addr.fields.offset = '0;
	end

	// miss goes out on port 1 in the lookup cycle already
	always_comb begin
		o_mem_req.read = ((state_q == cache_pkg::ST_LOOKUP) && !hit) ||
			(state_q == cache_pkg::ST_FILL);
		o_mem_req.addr = line_addr.raw;
	end

	assign fill_done = o_mem_req.read && i_mem_ready;

	assign o_ready = ((state_q == cache_pkg::ST_LOOKUP) && hit) ||
		(state_q == cache_pkg::ST_RESPOND);
	assign o_rdata = cur_line[req_addr_q.fields.offset];

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= cache_pkg::ST_IDLE;
			valid_q <= '0;
		end else begin
			case (state_q)
				cache_pkg::ST_IDLE: begin
					if (i_req.read)
						state_q <= cache_pkg::ST_LOOKUP;
				end
				cache_pkg::ST_LOOKUP: begin
					if (hit)
						state_q <= cache_pkg::ST_IDLE;
					else if (i_mem_ready)
						state_q <= cache_pkg::ST_RESPOND;
					else
						state_q <= cache_pkg::ST_FILL;
				end
				cache_pkg::ST_FILL: begin
					if (i_mem_ready)
						state_q <= cache_pkg::ST_RESPOND;
				end
				default: state_q <= cache_pkg::ST_IDLE;
			endcase
			if (fill_done)
				valid_q[req_addr_q.fields.index] <= 1'b1;
		end
	end

	// address capture and line storage
	always_ff @(posedge clk) begin
		if ((state_q == cache_pkg::ST_IDLE) && i_req.read)
			req_addr_q.raw <= i_req.addr;
		if (fill_done) begin
			tag_mem[req_addr_q.fields.index]  <= req_addr_q.fields.tag;
			line_mem[req_addr_q.fields.index] <= i_mem_data;
		end
	end

	// the read waits out a port 1 still held by the data cache
	a_rd_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_mem_req.read && !i_mem_ready |=> o_mem_req.read && $stable(o_mem_req.addr));

endmodule

// File: data_cache.sv
`timescale 1ns/10ps

module data_cache (
	input  logic                         clk,
	input  logic                         i_arst_n,
	input  cache_pkg::cpu_req_t          i_req,
	output logic                         o_ready,
	output logic [cache_pkg::WORD_W-1:0] o_rdata,
	output cache_pkg::mem_rd_req_t       o_mem_req,
	input  logic                         i_mem_ready,
	input  cache_pkg::cache_line_t       i_mem_data,
	output cache_pkg::mem_wr_req_t       o_mem_wr,
	input  logic                         i_mem_ack,
	input  logic                         i_bus_access
);

	logic [2:0]                      state_q;
	cache_pkg::cache_addr_u          req_addr_q;
	cache_pkg::cache_addr_u          line_addr;
	logic                            is_write_q;
	logic [cache_pkg::WORD_W-1:0]    wdata_q;
	logic [cache_pkg::NUM_LINES-1:0] valid_q;
	logic [cache_pkg::TAG_W-1:0]     tag_mem [cache_pkg::NUM_LINES];
	logic [cache_pkg::LINE_W-1:0]    line_mem [cache_pkg::NUM_LINES];
	cache_pkg::cache_line_t          cur_line;
	cache_pkg::cache_line_t          merged_line;
	logic                            hit;
	logic                            fill_done;
	logic                            line_we;

	always_comb begin
		cur_line = line_mem[req_addr_q.fields.index];
		hit = valid_q[req_addr_q.fields.index] &&
			(tag_mem[req_addr_q.fields.index] == req_addr_q.fields.tag);
		line_addr = req_addr_q;
		line_addr.fields.offset = '0;
	end

	always_comb begin
		o_mem_req.read = ((state_q == cache_pkg::ST_LOOKUP) && !hit) ||
			(state_q == cache_pkg::ST_FILL);
		o_mem_req.addr = line_addr.raw;
	end

	assign fill_done = o_mem_req.read && i_mem_ready;

	// write-allocate merges the store word into the hit line or the fill
	always_comb begin
		merged_line = o_mem_req.read ? i_mem_data : cur_line;
		if (is_write_q)
			merged_line[req_addr_q.fields.offset] = wdata_q;
	end

	assign line_we = fill_done ||
		((state_q == cache_pkg::ST_LOOKUP) && hit && is_write_q);

	// port 2 writes the stored line that already holds the new word
	always_comb begin
		o_mem_wr.write = (state_q == cache_pkg::ST_WRITE);
		o_mem_wr.addr  = line_addr.raw;
		o_mem_wr.data  = cur_line;
	end

	// read hits answer in lookup and all else from respond
	assign o_ready = ((state_q == cache_pkg::ST_LOOKUP) && hit && !is_write_q) ||
		(state_q == cache_pkg::ST_RESPOND);
	assign o_rdata = cur_line[req_addr_q.fields.offset];

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= cache_pkg::ST_IDLE;
			valid_q <= '0;
		end else begin
			case (state_q)
				cache_pkg::ST_IDLE: begin
					if (i_req.read || i_req.write)
						state_q <= cache_pkg::ST_LOOKUP;
				end
				cache_pkg::ST_LOOKUP: begin
					if (hit)
						state_q <= is_write_q ? cache_pkg::ST_WR_WAIT : cache_pkg::ST_IDLE;
					else if (i_mem_ready)
						state_q <= is_write_q ? cache_pkg::ST_WR_WAIT
							: cache_pkg::ST_RESPOND;
					else
						state_q <= cache_pkg::ST_FILL;
				end
				cache_pkg::ST_FILL: begin
					if (i_mem_ready)
						state_q <= is_write_q ? cache_pkg::ST_WR_WAIT
							: cache_pkg::ST_RESPOND;
				end
				// hold off while the DMA owns port 2
				cache_pkg::ST_WR_WAIT: begin
					if (i_bus_access)
						state_q <= cache_pkg::ST_WRITE;
				end
				cache_pkg::ST_WRITE: begin
					if (i_mem_ack)
						state_q <= cache_pkg::ST_RESPOND;
				end
				default: state_q <= cache_pkg::ST_IDLE;
			endcase
			if (fill_done)
				valid_q[req_addr_q.fields.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if ((state_q == cache_pkg::ST_IDLE) && (i_req.read || i_req.write)) begin
			req_addr_q.raw <= i_req.addr;
			is_write_q     <= i_req.write;
			wdata_q        <= i_req.wdata;
		end
		if (fill_done)
			tag_mem[req_addr_q.fields.index] <= req_addr_q.fields.tag;
		if (line_we)
			line_mem[req_addr_q.fields.index] <= merged_line;
	end

	// bus access is still high when the write appears, so no grant overlaps it
	a_wr_start: assert property (@(posedge clk) disable iff (!i_arst_n)
		$rose(o_mem_wr.write) |-> i_bus_access);

	a_wr_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_mem_wr.write && !i_mem_ack |=>
			o_mem_wr.write && $stable(o_mem_wr.addr) && $stable(o_mem_wr.data));

endmodule

// File: mem_port_ctrl.sv
`timescale 1ns/10ps

module mem_port_ctrl (
	input  logic                   clk,
	input  logic                   i_arst_n,
	input  cache_pkg::mem_rd_req_t i_irq,
	input  cache_pkg::mem_rd_req_t i_drq,
	output logic                   o_i_ready,
	output logic                   o_d_ready,
	input  cache_pkg::mem_wr_req_t i_dwr,
	output logic                   o_d_ack,
	output cache_pkg::mem_rd_req_t o_mem1,
	input  logic                   i_mem1_ready,
	output cache_pkg::mem_wr_req_t o_mem2,
	input  logic                   i_mem2_ack,
	output logic                   o_bus_access,
	input  logic                   i_bus_request,
	output logic                   o_bus_grant,
	input  logic                   i_ex_interrupt,
	output cache_pkg::dma_cmd_t    o_dma_cmd
);

	logic p1_busy_q;
	logic p1_dc_q;
	logic p1_dc_sel;
	logic grant_q;

	// instruction side wins unless a data read already holds the port
	assign p1_dc_sel = p1_busy_q ? p1_dc_q : !i_irq.read;
	assign o_mem1    = p1_dc_sel ? i_drq : i_irq;
	assign o_i_ready = i_mem1_ready && !p1_dc_sel;
	assign o_d_ready = i_mem1_ready && p1_dc_sel;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			p1_busy_q <= 1'b0;
			p1_dc_q   <= 1'b0;
		end else if (o_mem1.read && !i_mem1_ready) begin
			p1_busy_q <= 1'b1;
			p1_dc_q   <= p1_dc_sel;
		end else if (i_mem1_ready) begin
			p1_busy_q <= 1'b0;
		end
	end

	// grant rises at once when port 2 is free and drops a cycle after the request
	assign o_bus_grant  = grant_q || (i_bus_request && !i_dwr.write);
	assign o_bus_access = !o_bus_grant;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			grant_q <= 1'b0;
		else
			grant_q <= i_bus_request && o_bus_grant;
	end

	assign o_mem2  = o_bus_grant ? '0 : i_dwr;
	assign o_d_ack = i_mem2_ack && !o_bus_grant;

	always_comb begin
		o_dma_cmd = '0;
		if (i_ex_interrupt) begin
			o_dma_cmd.valid = 1'b1;
			o_dma_cmd.addr  = cache_pkg::DMA_ADDR;
			o_dma_cmd.len   = cache_pkg::DMA_LEN;
		end
	end

	// the data cache never holds a line write under a grant
	a_grant_wr: assert property (@(posedge clk) disable iff (!i_arst_n)
		!(o_bus_grant && i_dwr.write));

	a_p1_owner: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_mem1.read && !i_mem1_ready |=>
			o_mem1.read && $stable(o_mem1.addr));

endmodule

// File: cache_subsystem.sv
`timescale 1ns/10ps

module cache_subsystem (
	input  logic                         clk,
	input  logic                         i_arst_n,
	input  cache_pkg::cpu_req_t          i_ireq,
	output logic                         o_iready,
	output logic [cache_pkg::WORD_W-1:0] o_irdata,
	input  cache_pkg::cpu_req_t          i_dreq,
	output logic                         o_dready,
	output logic [cache_pkg::WORD_W-1:0] o_drdata,
	output cache_pkg::mem_rd_req_t       o_mem1,
	input  logic                         i_mem1_ready,
	input  cache_pkg::cache_line_t       i_mem1_data,
	output cache_pkg::mem_wr_req_t       o_mem2,
	input  logic                         i_mem2_ack,
	input  logic                         i_bus_request,
	output logic                         o_bus_grant,
	input  logic                         i_ex_interrupt,
	output cache_pkg::dma_cmd_t          o_dma_cmd
);

	cache_pkg::mem_rd_req_t ic_mem_req;
	cache_pkg::mem_rd_req_t dc_mem_req;
	cache_pkg::mem_wr_req_t dc_mem_wr;
	logic                   ic_mem_ready;
	logic                   dc_mem_ready;
	logic                   dc_mem_ack;
	logic                   bus_access;

	instr_cache u_instr_cache (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_req       (i_ireq),
		.o_ready     (o_iready),
		.o_rdata     (o_irdata),
		.o_mem_req   (ic_mem_req),
		.i_mem_ready (ic_mem_ready),
		.i_mem_data  (i_mem1_data)
	);

	// both caches see the same port 1 line but only the owner gets ready
	data_cache u_data_cache (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_req        (i_dreq),
		.o_ready      (o_dready),
		.o_rdata      (o_drdata),
		.o_mem_req    (dc_mem_req),
		.i_mem_ready  (dc_mem_ready),
		.i_mem_data   (i_mem1_data),
		.o_mem_wr     (dc_mem_wr),
		.i_mem_ack    (dc_mem_ack),
		.i_bus_access (bus_access)
	);

	mem_port_ctrl u_mem_port_ctrl (
		.clk            (clk),
		.i_arst_n       (i_arst_n),
		.i_irq          (ic_mem_req),
		.i_drq          (dc_mem_req),
		.o_i_ready      (ic_mem_ready),
		.o_d_ready      (dc_mem_ready),
		.i_dwr          (dc_mem_wr),
		.o_d_ack        (dc_mem_ack),
		.o_mem1         (o_mem1),
		.i_mem1_ready   (i_mem1_ready),
		.o_mem2         (o_mem2),
		.i_mem2_ack     (i_mem2_ack),
		.o_bus_access   (bus_access),
		.i_bus_request  (i_bus_request),
		.o_bus_grant    (o_bus_grant),
		.i_ex_interrupt (i_ex_interrupt),
		.o_dma_cmd      (o_dma_cmd)
	);

endmodule

// File: tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model (
	input  logic                   clk,
	input  logic                   i_arst_n,
	input  cache_pkg::mem_rd_req_t i_mem1,
	output logic                   o_mem1_ready,
	output cache_pkg::cache_line_t o_mem1_data,
	input  cache_pkg::mem_wr_req_t i_mem2,
	output logic                   o_mem2_ack,
	input  logic [3:0]             i_lat1,
	input  logic [3:0]             i_lat2
);

	logic [15:0] mem [65536];
	logic [3:0]  cnt1;
	logic [3:0]  cnt2;

	// start contents depend on every address bit
	function automatic logic [15:0] fill_word(input logic [15:0] a);
		return (a * 16'h9e37) ^ {a[7:0], a[15:8]};
	endfunction

	initial begin
		for (int a = 0; a < 65536; a++)
			mem[a] = fill_word(16'(a));
	end

	// port 1 answers a held read after the latency given by the testbench
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_mem1_ready <= 1'b0;
			o_mem1_data  <= '0;
			cnt1         <= '0;
		end else if (o_mem1_ready) begin
			o_mem1_ready <= 1'b0;
			cnt1         <= '0;
		end else if (i_mem1.read) begin
			if (cnt1 >= i_lat1) begin
				o_mem1_ready <= 1'b1;
				for (int k = 0; k < 4; k++)
					o_mem1_data[k] <= mem[{i_mem1.addr[15:2], 2'(k)}];
			end else begin
				cnt1 <= cnt1 + 4'd1;
			end
		end else begin
			cnt1 <= '0;
		end
	end

	// port 2 line write acked with a pulse once the latency is over
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_mem2_ack <= 1'b0;
			cnt2       <= '0;
		end else if (o_mem2_ack) begin
			o_mem2_ack <= 1'b0;
			cnt2       <= '0;
		end else if (i_mem2.write) begin
			if (cnt2 >= i_lat2)
				o_mem2_ack <= 1'b1;
			else
				cnt2 <= cnt2 + 4'd1;
		end else begin
			cnt2 <= '0;
		end
	end

	always @(posedge clk) begin
		if (i_arst_n && i_mem2.write && !o_mem2_ack && (cnt2 >= i_lat2)) begin
			for (int k = 0; k < 4; k++)
				mem[{i_mem2.addr[15:2], 2'(k)}] <= i_mem2.data[k];
		end
	end

endmodule

// File: tb_cache_subsystem.sv
`timescale 1ns/10ps

module tb_cache_subsystem;

	logic                   clk;
	logic                   i_arst_n;
	cache_pkg::cpu_req_t    ireq;
	cache_pkg::cpu_req_t    dreq;
	logic                   iready;
	logic                   dready;
	logic [15:0]            irdata;
	logic [15:0]            drdata;
	cache_pkg::mem_rd_req_t mem1;
	logic                   mem1_ready;
	cache_pkg::cache_line_t mem1_data;
	cache_pkg::mem_wr_req_t mem2;
	logic                   mem2_ack;
	logic                   bus_request;
	logic                   bus_grant;
	logic                   ex_interrupt;
	cache_pkg::dma_cmd_t    dma_cmd;
	logic [3:0]             lat1;
	logic [3:0]             lat2;
	int                     seed;
	logic [15:0]            shadow [65536];
	logic                   exp_ihit;
	logic                   both_miss;
	logic [7:0]             itag_v;
	logic [10:0]            itag [8];
	cache_pkg::cache_line_t exp_wline;

	cache_subsystem i_cache_subsystem (
		.clk            (clk),
		.i_arst_n       (i_arst_n),
		.i_ireq         (ireq),
		.o_iready       (iready),
		.o_irdata       (irdata),
		.i_dreq         (dreq),
		.o_dready       (dready),
		.o_drdata       (drdata),
		.o_mem1         (mem1),
		.i_mem1_ready   (mem1_ready),
		.i_mem1_data    (mem1_data),
		.o_mem2         (mem2),
		.i_mem2_ack     (mem2_ack),
		.i_bus_request  (bus_request),
		.o_bus_grant    (bus_grant),
		.i_ex_interrupt (ex_interrupt),
		.o_dma_cmd      (dma_cmd)
	);

	tb_mem_model u_mem_model (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_mem1       (mem1),
		.o_mem1_ready (mem1_ready),
		.o_mem1_data  (mem1_data),
		.i_mem2       (mem2),
		.o_mem2_ack   (mem2_ack),
		.i_lat1       (lat1),
		.i_lat2       (lat2)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic fail_and_stop();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [63:0] expv,
		input logic [63:0] gotv);
		$display("** Error: %s expected 0x%h got 0x%h", name, expv, gotv);
		fail_and_stop();
	endtask

	task automatic text_error(input string msg);
		$display("error: %s", msg);
		fail_and_stop();
	endtask

	// expected memory contents start with the memory model pattern
	function automatic logic [15:0] start_word(input logic [15:0] a);
		return (a * 16'h9e37) ^ {a[7:0], a[15:8]};
	endfunction

	// line that a port 2 write of the current data request must carry
	always_comb begin
		for (int k = 0; k < 4; k++)
			exp_wline[k] = shadow[{dreq.addr[15:2], 2'(k)}];
		exp_wline[dreq.addr[1:0]] = dreq.wdata;
	end

	// sampled at the falling edge away from the DUT update edge
	task automatic wait_ready(input bit data_side, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!(data_side ? dready : iready) && n < 300) begin
			n++;
			@(negedge clk);
		end
		if (n >= 300)
			text_error({"timeout waiting for ready of ", what});
	endtask

	task automatic fetch(input logic [15:0] a);
		@(posedge clk);
		ireq.read <= 1'b1;
		ireq.addr <= a;
		exp_ihit  <= itag_v[a[4:2]] && (itag[a[4:2]] == a[15:5]);
		lat1      <= 4'($random(seed));
		wait_ready(1'b0, "instruction fetch");
		@(posedge clk);
		ireq.read <= 1'b0;
		exp_ihit  <= 1'b0;
		itag_v[a[4:2]] = 1'b1;
		itag[a[4:2]]   = a[15:5];
	endtask

	task automatic data_access(input bit wr, input logic [15:0] a, input logic [15:0] w);
		@(posedge clk);
		dreq.read  <= !wr;
		dreq.write <= wr;
		dreq.addr  <= a;
		dreq.wdata <= w;
		lat1       <= 4'($random(seed));
		lat2       <= 4'($random(seed));
		wait_ready(1'b1, wr ? "data write" : "data read");
		if (wr)
			shadow[a] = w;
		@(posedge clk);
		dreq.read  <= 1'b0;
		dreq.write <= 1'b0;
	endtask

	task automatic dma_burst();
		repeat ($unsigned($random(seed)) % 5)
			@(posedge clk);
		bus_request <= 1'b1;
		repeat (2 + $unsigned($random(seed)) % 5)
			@(posedge clk);
		bus_request <= 1'b0;
	endtask

	// random interrupts that the DMA command follows
	always @(posedge clk) begin
		if (i_arst_n)
			ex_interrupt <= (($random(seed) & 7) == 0);
	end

	a_reset: assert property (@(posedge clk) !i_arst_n && $past(!i_arst_n) |->
		!iready && !dready && !mem1.read && !mem2.write && !bus_grant && !dma_cmd.valid)
		else text_error("outputs not idle during reset");

	a_irdata: assert property (@(posedge clk) disable iff (!i_arst_n)
		iready |-> irdata == shadow[ireq.addr])
		else value_error("o_irdata", shadow[ireq.addr], $sampled(irdata));

	a_ihit_time: assert property (@(posedge clk) disable iff (!i_arst_n)
		ireq.read && !$past(ireq.read) && exp_ihit |=>
			iready && !(mem1.read && mem1.addr == {ireq.addr[15:2], 2'b00}))
		else text_error("instruction hit did not answer one cycle after the request");

	a_drdata: assert property (@(posedge clk) disable iff (!i_arst_n)
		dready && dreq.read |-> drdata == shadow[dreq.addr])
		else value_error("o_drdata", shadow[dreq.addr], $sampled(drdata));

	a_wr_addr: assert property (@(posedge clk) disable iff (!i_arst_n)
		mem2.write |-> mem2.addr == {dreq.addr[15:2], 2'b00})
		else value_error("o_mem2.addr", {dreq.addr[15:2], 2'b00}, $sampled(mem2.addr));

	a_wr_line: assert property (@(posedge clk) disable iff (!i_arst_n)
		mem2.write |-> mem2.data == exp_wline)
		else value_error("o_mem2.data", exp_wline, $sampled(mem2.data));

	// instruction side goes first when both caches miss together
	a_p1_first: assert property (@(posedge clk) disable iff (!i_arst_n)
		ireq.read && !$past(ireq.read) && dreq.read && !$past(dreq.read) && both_miss |=>
			mem1.read && mem1.addr == {ireq.addr[15:2], 2'b00})
		else text_error("port 1 did not serve the instruction cache first");

	a_p1_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
		mem1.read && !mem1_ready |=> mem1.read && $stable(mem1.addr))
		else text_error("port 1 read changed before it was answered");

	a_grant_rise: assert property (@(posedge clk) disable iff (!i_arst_n)
		$rose(bus_grant) |-> bus_request && !($past(mem2.write) && !$past(mem2_ack)))
		else text_error("bus grant rose without a request or over a line write");

	a_grant_no_wr: assert property (@(posedge clk) disable iff (!i_arst_n)
		bus_grant |-> !mem2.write)
		else text_error("port 2 write while the bus was granted");

	a_grant_fall: assert property (@(posedge clk) disable iff (!i_arst_n)
		$fell(bus_request) && $past(bus_grant) |-> bus_grant ##1 !bus_grant)
		else text_error("bus grant did not fall one cycle after the request");

	a_dma_cmd: assert property (@(posedge clk) disable iff (!i_arst_n)
		dma_cmd == (ex_interrupt ? 33'h1_0017_000c : 33'h0))
		else value_error("o_dma_cmd", $sampled(ex_interrupt) ? 33'h1_0017_000c : 33'h0,
			$sampled(dma_cmd));

	// watchdog for the whole run
	initial begin
		repeat (200000)
			@(posedge clk);
		text_error("simulation did not finish in time");
	end

	initial begin
		logic [15:0] a;
		seed = 32'h5080_aa0e;
		i_arst_n = 1'b0;
		ireq = '0;
		dreq = '0;
		bus_request = 1'b0;
		ex_interrupt = 1'b0;
		lat1 = '0;
		lat2 = '0;
		exp_ihit = 1'b0;
		both_miss = 1'b0;
		itag_v = '0;
		for (int i = 0; i < 65536; i++)
			shadow[i] = start_word(16'(i));
		repeat (16)
			@(posedge clk);
		i_arst_n <= 1'b1;

		// fetch pairs where the second one stays in the line
		for (int i = 0; i < 40; i++) begin
			a = 16'h1000 + 16'($unsigned($random(seed)) % 256);
			fetch(a);
			fetch({a[15:2], 2'($random(seed))});
		end

		// mixed data reads and writes over a few tags per index
		for (int i = 0; i < 80; i++) begin
			a = 16'h8000 + 16'($unsigned($random(seed)) % 128);
			data_access(1'($random(seed)), a, 16'($random(seed)));
		end

		// fresh tags on both sides make both caches miss at once
		both_miss <= 1'b1;
		for (int i = 0; i < 10; i++) begin
			fork
				fetch(16'h1800 + 16'(i * 'h40));
				data_access(1'b0, 16'h9000 + 16'(i * 'h44), 16'h0);
			join
		end
		@(posedge clk);
		both_miss <= 1'b0;

		// line writes racing the DMA bus request
		for (int i = 0; i < 12; i++) begin
			a = 16'h8000 + 16'($unsigned($random(seed)) % 128);
			fork
				data_access(1'b1, a, 16'($random(seed)));
				dma_burst();
			join
			data_access(1'b0, a, 16'h0);
		end

		repeat (10)
			@(posedge clk);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: compile.f
cache_pkg.sv
instr_cache.sv
data_cache.sv
mem_port_ctrl.sv
cache_subsystem.sv
tb_mem_model.sv
tb_cache_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_subsystem
FLIST     ?= compile.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: build
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
